// ==== Makefile ====
TOP = tb_stq_data_path

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== files.f ====
src/stq_pkg.sv
src/stq_capture.sv
src/stq_rotator.sv
src/stq_array_write.sv
src/stq_data_path.sv
tests/tb_stq_data_path.sv

// ==== src/stq_array_write.sv ====
// Array write stage that gates disabled writes, masks bad ways and drives the data cache write port
`timescale 1ns/1ps

module stq_array_write #(
   parameter int NUM_WAYS = 8,
   parameter int INDEX_W  = 8
) (
   input  logic                                          nclk,
   input  logic                                          reset,

   input  logic                                          s3_valid,
   output logic                                          s3_ready,
   input  logic [INDEX_W-1:0]                            s3_index,
   input  logic [stq_pkg::QW_BYTES-1:0]                  s3_byte_en,
   input  stq_pkg::qw_u                                  s3_data,
   input  logic [stq_pkg::QW_BYTES-1:0]                  s3_par,
   input  logic [NUM_WAYS-1:0]                           s3_way_en,

   input  logic                                          dcache_disable,
   input  logic [NUM_WAYS-1:0]                           way_perr_inval,

   output logic                                          wr_valid,
   input  logic                                          wr_ready,
   output logic [NUM_WAYS-1:0]                           wr_way,
   output logic [INDEX_W-1:0]                            wr_index,
   output logic [stq_pkg::QW_BYTES-1:0]                  wr_byte_en,
   output logic [stq_pkg::DW_W+stq_pkg::BYTE_W-1:0]      wr_data_even,
   output logic [stq_pkg::DW_W+stq_pkg::BYTE_W-1:0]      wr_data_odd
);

   import stq_pkg::*;

   // Parity bits of one doubleword half
   localparam int HALF_PAR = QW_BYTES / 2;

   logic                     s3_fire;
   logic                     s3_keep;
   logic [NUM_WAYS-1:0]      way_masked;
   logic [DW_W+BYTE_W-1:0]   even_word;
   logic [DW_W+BYTE_W-1:0]   odd_word;

   assign s3_ready = !wr_valid || wr_ready;
   assign s3_fire  = s3_valid && s3_ready;

   // With the cache disabled the item is still taken, it just never reaches the array
   assign s3_keep = s3_fire && !dcache_disable;

   // Ways flagged by a parity error must not be written
   assign way_masked = s3_way_en & ~way_perr_inval;

   // Each half is its data followed by the parity of its eight lanes
   assign even_word = {s3_data.dwords[0], s3_par[HALF_PAR-1:0]};
   assign odd_word  = {s3_data.dwords[1], s3_par[QW_BYTES-1:HALF_PAR]};

   always_ff @(posedge nclk) begin
      if (reset) begin
         wr_valid <= 1'b0;
      end else if (s3_ready) begin
         wr_valid <= s3_valid && !dcache_disable;
      end
   end

   always_ff @(posedge nclk) begin
      if (s3_keep) begin
         wr_way       <= way_masked;
         wr_index     <= s3_index;
         wr_byte_en   <= s3_byte_en;
         wr_data_even <= even_word;
         wr_data_odd  <= odd_word;
      end
   end

   // A quadword is written into one way only
   a_way_onehot: assert property (@(posedge nclk) disable iff (reset)
      wr_valid |-> $onehot0(wr_way))
      else $error("array write selects more than one way %b", wr_way);

   // The array may stall the write, and the write must wait unchanged
   a_wr_stable: assert property (@(posedge nclk) disable iff (reset)
      (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr_way) && $stable(wr_index) &&
                                   $stable(wr_byte_en) && $stable(wr_data_even) &&
                                   $stable(wr_data_odd)))
      else $error("array write changed while stalled");

endmodule

// ==== src/stq_capture.sv ====
// Store capture stage that accepts requests, decodes the operand size and sets up the rotation
`timescale 1ns/1ps

module stq_capture #(
   parameter int NUM_WAYS = 8,
   parameter int INDEX_W  = 8
) (
   input  logic                                  nclk,
   input  logic                                  reset,

   input  logic                                  req_valid,
   output logic                                  req_ready,
   input  logic [INDEX_W+stq_pkg::OFFSET_W-1:0]  req_addr,
   input  logic [2:0]                            req_op_size,
   input  logic                                  req_le_mode,
   input  logic [stq_pkg::QW_BYTES-1:0]          req_byte_en,
   input  stq_pkg::qw_u                          req_data,
   input  logic [stq_pkg::QW_BYTES-1:0]          req_par,
   input  logic [NUM_WAYS-1:0]                   req_way_en,

   output logic                                  s2_valid,
   input  logic                                  s2_ready,
   output logic [INDEX_W-1:0]                    s2_index,
   output logic [stq_pkg::OFFSET_W-1:0]          s2_rot_amt,
   output logic                                  s2_reverse,
   output logic [stq_pkg::QW_BYTES-1:0]          s2_byte_en,
   output stq_pkg::qw_u                          s2_data,
   output logic [stq_pkg::QW_BYTES-1:0]          s2_par,
   output logic [NUM_WAYS-1:0]                   s2_way_en
);

   import stq_pkg::*;

   logic [OFFSET_W:0]   size_bytes;
   logic [OFFSET_W-1:0] req_offset;
   logic [OFFSET_W-1:0] be_rot_amt;
   logic [OFFSET_W-1:0] rot_amt;
   logic                size_legal;
   logic                req_fire;

   assign req_offset = req_addr[OFFSET_W-1:0];
   assign req_ready  = !s2_valid || s2_ready;
   assign req_fire   = req_valid && req_ready;

   // Byte count of the operand, zero for an illegal code
   always_comb begin
      case (req_op_size)
         OP_SIZE_1:  size_bytes = 5'd1;
         OP_SIZE_2:  size_bytes = 5'd2;
         OP_SIZE_4:  size_bytes = 5'd4;
         OP_SIZE_8:  size_bytes = 5'd8;
         OP_SIZE_16: size_bytes = 5'd16;
         default:    size_bytes = 5'd0;
      endcase
   end

   assign size_legal = |size_bytes;

   // Big endian data is right justified in the quadword.
   // Rotating by offset plus size lands its first byte on the offset lane.
   // A full quadword wraps back to the plain offset.
   assign be_rot_amt = req_offset + size_bytes[OFFSET_W-1:0];

   // Little endian data is reversed first, so only the offset remains
   assign rot_amt = req_le_mode ? req_offset : be_rot_amt;

   always_ff @(posedge nclk) begin
      if (reset) begin
         s2_valid <= 1'b0;
      end else if (req_ready) begin
         s2_valid <= req_valid;
      end
   end

   always_ff @(posedge nclk) begin
      if (req_fire) begin
         s2_index   <= req_addr[INDEX_W+OFFSET_W-1:OFFSET_W];
         s2_rot_amt <= rot_amt;
         s2_reverse <= req_le_mode;
         s2_byte_en <= req_byte_en;
         s2_data    <= req_data;
         s2_par     <= req_par;
         s2_way_en  <= req_way_en;
      end
   end

   // The requester must only send the five defined size codes
   a_size_legal: assert property (@(posedge nclk) disable iff (reset)
      req_fire |-> size_legal)
      else $error("illegal store size code %b accepted", req_op_size);

endmodule

// ==== src/stq_data_path.sv ====
// Top of the store data alignment path that chains capture, rotator and array write stages
`timescale 1ns/1ps

module stq_data_path #(
   parameter int NUM_WAYS = 8,
   parameter int INDEX_W  = 8
) (
   input  logic                                          nclk,
   input  logic                                          reset,

   input  logic                                          req_valid,
   output logic                                          req_ready,
   input  logic [INDEX_W+stq_pkg::OFFSET_W-1:0]          req_addr,
   input  logic [2:0]                                    req_op_size,
   input  logic                                          req_le_mode,
   input  logic [stq_pkg::QW_BYTES-1:0]                  req_byte_en,
   input  stq_pkg::qw_u                                  req_data,
   input  logic [stq_pkg::QW_BYTES-1:0]                  req_par,
   input  logic [NUM_WAYS-1:0]                           req_way_en,

   input  logic                                          dcache_disable,
   input  logic [NUM_WAYS-1:0]                           way_perr_inval,

   output logic                                          wr_valid,
   input  logic                                          wr_ready,
   output logic [NUM_WAYS-1:0]                           wr_way,
   output logic [INDEX_W-1:0]                            wr_index,
   output logic [stq_pkg::QW_BYTES-1:0]                  wr_byte_en,
   output logic [stq_pkg::DW_W+stq_pkg::BYTE_W-1:0]      wr_data_even,
   output logic [stq_pkg::DW_W+stq_pkg::BYTE_W-1:0]      wr_data_odd
);

   import stq_pkg::*;

   // Capture to rotator
   logic                s2_valid;
   logic                s2_ready;
   logic [INDEX_W-1:0]  s2_index;
   logic [OFFSET_W-1:0] s2_rot_amt;
   logic                s2_reverse;
   logic [QW_BYTES-1:0] s2_byte_en;
   qw_u                 s2_data;
   logic [QW_BYTES-1:0] s2_par;
   logic [NUM_WAYS-1:0] s2_way_en;

   // Rotator to array write
   logic                s3_valid;
   logic                s3_ready;
   logic [INDEX_W-1:0]  s3_index;
   logic [QW_BYTES-1:0] s3_byte_en;
   qw_u                 s3_data;
   logic [QW_BYTES-1:0] s3_par;
   logic [NUM_WAYS-1:0] s3_way_en;

   stq_capture #(
      .NUM_WAYS (NUM_WAYS),
      .INDEX_W  (INDEX_W)
   ) capture_i (
      .nclk        (nclk),
      .reset       (reset),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req_addr    (req_addr),
      .req_op_size (req_op_size),
      .req_le_mode (req_le_mode),
      .req_byte_en (req_byte_en),
      .req_data    (req_data),
      .req_par     (req_par),
      .req_way_en  (req_way_en),
      .s2_valid    (s2_valid),
      .s2_ready    (s2_ready),
      .s2_index    (s2_index),
      .s2_rot_amt  (s2_rot_amt),
      .s2_reverse  (s2_reverse),
      .s2_byte_en  (s2_byte_en),
      .s2_data     (s2_data),
      .s2_par      (s2_par),
      .s2_way_en   (s2_way_en)
   );

   stq_rotator #(
      .NUM_WAYS (NUM_WAYS),
      .INDEX_W  (INDEX_W)
   ) rotator_i (
      .nclk       (nclk),
      .reset      (reset),
      .s2_valid   (s2_valid),
      .s2_ready   (s2_ready),
      .s2_index   (s2_index),
      .s2_rot_amt (s2_rot_amt),
      .s2_reverse (s2_reverse),
      .s2_byte_en (s2_byte_en),
      .s2_data    (s2_data),
      .s2_par     (s2_par),
      .s2_way_en  (s2_way_en),
      .s3_valid   (s3_valid),
      .s3_ready   (s3_ready),
      .s3_index   (s3_index),
      .s3_byte_en (s3_byte_en),
      .s3_data    (s3_data),
      .s3_par     (s3_par),
      .s3_way_en  (s3_way_en)
   );

   stq_array_write #(
      .NUM_WAYS (NUM_WAYS),
      .INDEX_W  (INDEX_W)
   ) array_write_i (
      .nclk           (nclk),
      .reset          (reset),
      .s3_valid       (s3_valid),
      .s3_ready       (s3_ready),
      .s3_index       (s3_index),
      .s3_byte_en     (s3_byte_en),
      .s3_data        (s3_data),
      .s3_par         (s3_par),
      .s3_way_en      (s3_way_en),
      .dcache_disable (dcache_disable),
      .way_perr_inval (way_perr_inval),
      .wr_valid       (wr_valid),
      .wr_ready       (wr_ready),
      .wr_way         (wr_way),
      .wr_index       (wr_index),
      .wr_byte_en     (wr_byte_en),
      .wr_data_even   (wr_data_even),
      .wr_data_odd    (wr_data_odd)
   );

endmodule

// ==== src/stq_pkg.sv ====
// Widths, size codes and the quadword union shared by every stage of the store alignment path
package stq_pkg;

   // A quadword is sixteen byte lanes.
   // Lane 0 is the lowest address.
   localparam int QW_BYTES = 16;
   localparam int BYTE_W   = 8;

   // The array is written as two doubleword halves
   localparam int DW_W     = 64;

   // Address bits that select a byte within the quadword
   localparam int OFFSET_W = 4;

   // Operand size codes carried on req_op_size.
   // No other code is legal.
   localparam logic [2:0] OP_SIZE_1  = 3'b001;
   localparam logic [2:0] OP_SIZE_2  = 3'b010;
   localparam logic [2:0] OP_SIZE_4  = 3'b100;
   localparam logic [2:0] OP_SIZE_8  = 3'b101;
   localparam logic [2:0] OP_SIZE_16 = 3'b110;

   // One quadword, read as byte lanes by the rotator.
   // The array writer reads the same word as doubleword halves.
   // Half 0 holds lanes 0 to 7.
   typedef union packed {
      logic [QW_BYTES-1:0][BYTE_W-1:0] bytes;
      logic [1:0][DW_W-1:0]            dwords;
   } qw_u;

endpackage

// ==== src/stq_rotator.sv ====
// Store rotator stage that reverses little endian stores and moves data and parity into lane order
`timescale 1ns/1ps

module stq_rotator #(
   parameter int NUM_WAYS = 8,
   parameter int INDEX_W  = 8
) (
   input  logic                                  nclk,
   input  logic                                  reset,

   input  logic                                  s2_valid,
   output logic                                  s2_ready,
   input  logic [INDEX_W-1:0]                    s2_index,
   input  logic [stq_pkg::OFFSET_W-1:0]          s2_rot_amt,
   input  logic                                  s2_reverse,
   input  logic [stq_pkg::QW_BYTES-1:0]          s2_byte_en,
   input  stq_pkg::qw_u                          s2_data,
   input  logic [stq_pkg::QW_BYTES-1:0]          s2_par,
   input  logic [NUM_WAYS-1:0]                   s2_way_en,

   output logic                                  s3_valid,
   input  logic                                  s3_ready,
   output logic [INDEX_W-1:0]                    s3_index,
   output logic [stq_pkg::QW_BYTES-1:0]          s3_byte_en,
   output stq_pkg::qw_u                          s3_data,
   output logic [stq_pkg::QW_BYTES-1:0]          s3_par,
   output logic [NUM_WAYS-1:0]                   s3_way_en
);

   import stq_pkg::*;

   // Each lane carries its parity bit on top of the byte, so both move together
   localparam int LANE_W = BYTE_W + 1;
   localparam int QW_LW  = QW_BYTES * LANE_W;

   logic [QW_BYTES-1:0][LANE_W-1:0] in_lanes;
   logic [QW_BYTES-1:0][LANE_W-1:0] rev_lanes;
   logic [QW_BYTES-1:0][LANE_W-1:0] rot_lanes;
   logic [QW_LW-1:0]                rot_flat;
   qw_u                             rot_data;
   logic [QW_BYTES-1:0]             rot_par;
   logic                            s2_fire;

   assign s2_ready = !s3_valid || s3_ready;
   assign s2_fire  = s2_valid && s2_ready;

   always_comb begin
      for (int i = 0; i < QW_BYTES; i++) begin
         in_lanes[i] = {s2_par[i], s2_data.bytes[i]};
      end
   end

   // Byte reversal for little endian stores
   always_comb begin
      for (int i = 0; i < QW_BYTES; i++) begin
         rev_lanes[i] = s2_reverse ? in_lanes[QW_BYTES-1-i] : in_lanes[i];
      end
   end

   // Log rotator, one level per amount bit.
   // Lane i moves up to lane (i + amount) mod 16.
   always_comb begin
      rot_flat = rev_lanes;
      for (int lvl = OFFSET_W - 1; lvl >= 0; lvl--) begin
         if (s2_rot_amt[lvl]) begin
            rot_flat = (rot_flat << ((1 << lvl) * LANE_W)) |
                       (rot_flat >> ((QW_BYTES - (1 << lvl)) * LANE_W));
         end
      end
   end

   assign rot_lanes = rot_flat;

   always_comb begin
      for (int i = 0; i < QW_BYTES; i++) begin
         rot_data.bytes[i] = rot_lanes[i][BYTE_W-1:0];
         rot_par[i]        = rot_lanes[i][BYTE_W];
      end
   end

   always_ff @(posedge nclk) begin
      if (reset) begin
         s3_valid <= 1'b0;
      end else if (s2_ready) begin
         s3_valid <= s2_valid;
      end
   end

   always_ff @(posedge nclk) begin
      if (s2_fire) begin
         s3_index   <= s2_index;
         s3_byte_en <= s2_byte_en;
         s3_data    <= rot_data;
         s3_par     <= rot_par;
         s3_way_en  <= s2_way_en;
      end
   end

endmodule

// ==== tests/tb_stq_data_path.sv ====
// Testbench for the store alignment path that sends random stores and checks each array write
`timescale 1ns/1ps

module tb_stq_data_path;

   import stq_pkg::*;

   localparam int NUM_WAYS = 8;
   localparam int INDEX_W  = 8;

   // About 300 transfers at a few cycles each under stalls, with a wide margin
   localparam int MAX_CYCLES = 5000;

   // Pipeline depth from acceptance to the write port
   localparam int PIPE_DEPTH = 3;

   // Once the array stops stalling, every stage empties well within this many cycles
   localparam int DRAIN_LIMIT = 4 * PIPE_DEPTH;

   typedef struct packed {
      logic [NUM_WAYS-1:0]      way;
      logic [INDEX_W-1:0]       index;
      logic [QW_BYTES-1:0]      byte_en;
      logic [DW_W+BYTE_W-1:0]   even_word;
      logic [DW_W+BYTE_W-1:0]   odd_word;
   } wr_item_t;

   logic                          nclk = 1'b0;
   logic                          reset = 1'b1;
   logic                          req_valid;
   logic                          req_ready;
   logic [INDEX_W+OFFSET_W-1:0]   req_addr;
   logic [2:0]                    req_op_size;
   logic                          req_le_mode;
   logic [QW_BYTES-1:0]           req_byte_en;
   qw_u                           req_data;
   logic [QW_BYTES-1:0]           req_par;
   logic [NUM_WAYS-1:0]           req_way_en;
   logic                          dcache_disable;
   logic [NUM_WAYS-1:0]           way_perr_inval;
   logic                          wr_valid;
   logic                          wr_ready;
   logic [NUM_WAYS-1:0]           wr_way;
   logic [INDEX_W-1:0]            wr_index;
   logic [QW_BYTES-1:0]           wr_byte_en;
   logic [DW_W+BYTE_W-1:0]        wr_data_even;
   logic [DW_W+BYTE_W-1:0]        wr_data_odd;

   integer     seed = 32'h847c240f;
   int         cycle_count = 0;
   logic       stall_mode = 1'b0;
   logic       next_ready;
   logic       pop_pending = 1'b0;
   logic       exp_avail = 1'b0;
   wr_item_t   exp_head;
   wr_item_t   exp_q[$];

   stq_data_path #(
      .NUM_WAYS (NUM_WAYS),
      .INDEX_W  (INDEX_W)
   ) dut_i (
      .nclk           (nclk),
      .reset          (reset),
      .req_valid      (req_valid),
      .req_ready      (req_ready),
      .req_addr       (req_addr),
      .req_op_size    (req_op_size),
      .req_le_mode    (req_le_mode),
      .req_byte_en    (req_byte_en),
      .req_data       (req_data),
      .req_par        (req_par),
      .req_way_en     (req_way_en),
      .dcache_disable (dcache_disable),
      .way_perr_inval (way_perr_inval),
      .wr_valid       (wr_valid),
      .wr_ready       (wr_ready),
      .wr_way         (wr_way),
      .wr_index       (wr_index),
      .wr_byte_en     (wr_byte_en),
      .wr_data_even   (wr_data_even),
      .wr_data_odd    (wr_data_odd)
   );

   always #50 nclk = ~nclk;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   function automatic int operand_bytes(input logic [2:0] code);
      case (code)
         OP_SIZE_1:  return 1;
         OP_SIZE_2:  return 2;
         OP_SIZE_4:  return 4;
         OP_SIZE_8:  return 8;
         default:    return 16;
      endcase
   endfunction

   function automatic logic [2:0] size_code_of(input int sel);
      case (sel)
         0:       return OP_SIZE_1;
         1:       return OP_SIZE_2;
         2:       return OP_SIZE_4;
         3:       return OP_SIZE_8;
         default: return OP_SIZE_16;
      endcase
   endfunction

   // Operand byte k lands in lane (offset + k) mod 16 and its parity bit goes with it
   function automatic wr_item_t expected_write(input logic [INDEX_W+OFFSET_W-1:0] addr,
                                               input logic [2:0] size, input logic le,
                                               input logic [QW_BYTES-1:0] be,
                                               input logic [127:0] data,
                                               input logic [QW_BYTES-1:0] par,
                                               input logic [NUM_WAYS-1:0] way,
                                               input logic [NUM_WAYS-1:0] perr);
      wr_item_t                        item;
      logic [QW_BYTES-1:0][BYTE_W-1:0] lane_byte;
      logic [QW_BYTES-1:0]             lane_par;
      int                              nbytes;
      int                              offset;
      int                              src;
      int                              lane;
      nbytes = operand_bytes(size);
      offset = int'(addr[OFFSET_W-1:0]);
      for (int k = 0; k < QW_BYTES; k++) begin
         src = le ? (QW_BYTES - 1 - k) : ((QW_BYTES - nbytes + k) % QW_BYTES);
         lane = (offset + k) % QW_BYTES;
         lane_byte[lane] = data[src*BYTE_W +: BYTE_W];
         lane_par[lane] = par[src];
      end
      for (int l = 0; l < QW_BYTES / 2; l++) begin
         item.even_word[BYTE_W + BYTE_W*l +: BYTE_W] = lane_byte[l];
         item.even_word[l] = lane_par[l];
         item.odd_word[BYTE_W + BYTE_W*l +: BYTE_W] = lane_byte[QW_BYTES/2 + l];
         item.odd_word[l] = lane_par[QW_BYTES/2 + l];
      end
      item.way = way & ~perr;
      item.index = addr[INDEX_W+OFFSET_W-1:OFFSET_W];
      item.byte_en = be;
      return item;
   endfunction

   // Holds the request until the DUT takes it
   task automatic send_request(input logic [2:0] size, input logic [3:0] offset,
                               input logic le);
      logic [31:0] r;
      logic        accepted;
      r = $random(seed);
      req_addr = {r[INDEX_W-1:0], offset};
      req_op_size = size;
      req_le_mode = le;
      req_byte_en = r[31:16];
      req_way_en = NUM_WAYS'(1) << (r[15:8] % NUM_WAYS);
      req_data.dwords[0] = {$random(seed), $random(seed)};
      req_data.dwords[1] = {$random(seed), $random(seed)};
      r = $random(seed);
      req_par = r[15:0];
      req_valid = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
         @(negedge nclk);
         accepted = req_ready;
         @(posedge nclk);
         #1;
      end
      req_valid = 1'b0;
   endtask

   task automatic send_random();
      logic [31:0] r;
      r = $random(seed);
      if (r[3:2] == 2'b00) begin
         @(posedge nclk);
         #1;
      end
      send_request(size_code_of(int'(r[31:8] % 5)), r[7:4], r[0]);
   endtask

   // Waits for all expected writes, then lets discarded items leave the pipeline
   task automatic drain_pipeline();
      int waited;
      stall_mode = 1'b0;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(posedge nclk);
         #1;
         waited++;
      end
      repeat (PIPE_DEPTH) begin
         @(posedge nclk);
         #1;
      end
   endtask

   always begin
      @(negedge nclk);
      next_ready = !stall_mode || seed_bit();
      @(posedge nclk);
      #1;
      wr_ready = next_ready;
   end

   function automatic logic seed_bit();
      logic [31:0] r;
      r = $random(seed);
      return r[0];
   endfunction

   // Reference model bookkeeping on the falling edge, where handshakes are settled
   always @(negedge nclk) begin
      if (reset) begin
         exp_q.delete();
         pop_pending = 1'b0;
      end else begin
         if (pop_pending && exp_q.size() != 0) begin
            exp_q.delete(0);
         end
         if (req_valid && req_ready && !dcache_disable) begin
            exp_q.push_back(expected_write(req_addr, req_op_size, req_le_mode, req_byte_en,
                                           req_data, req_par, req_way_en, way_perr_inval));
         end
         pop_pending = wr_valid && wr_ready;
      end
      exp_avail = (exp_q.size() != 0);
      if (exp_avail) begin
         exp_head = exp_q[0];
      end
   end

   always @(posedge nclk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         stop_on_error($sformatf("Timeout: the run did not finish within %0d cycles",
                                 MAX_CYCLES));
      end
   end

   a_reset_idle: assert property (@(posedge nclk) $fell(reset) |-> (!wr_valid && req_ready))
      else stop_on_error($sformatf("FAILED at %0t: wr_valid or req_ready wrong after reset",
                                   $time));

   a_write_expected: assert property (@(posedge nclk) disable iff (reset)
      (wr_valid && wr_ready) |-> exp_avail)
      else stop_on_error($sformatf("FAILED at %0t: array write with no store pending", $time));

   a_write_way: assert property (@(posedge nclk) disable iff (reset)
      (wr_valid && wr_ready && exp_avail) |-> (wr_way == exp_head.way))
      else stop_on_error($sformatf("FAILED at %0t: wr_way %b, expected %b", $time,
                                   $sampled(wr_way), exp_head.way));

   a_write_addr: assert property (@(posedge nclk) disable iff (reset)
      (wr_valid && wr_ready && exp_avail) |->
         (wr_index == exp_head.index && wr_byte_en == exp_head.byte_en))
      else stop_on_error($sformatf("FAILED at %0t: wr_index %h wr_byte_en %h, expected %h %h",
                                   $time, $sampled(wr_index), $sampled(wr_byte_en),
                                   exp_head.index, exp_head.byte_en));

   a_write_data: assert property (@(posedge nclk) disable iff (reset)
      (wr_valid && wr_ready && exp_avail) |->
         (wr_data_even == exp_head.even_word && wr_data_odd == exp_head.odd_word))
      else stop_on_error($sformatf("FAILED at %0t: write data %h %h, expected %h %h", $time,
                                   $sampled(wr_data_odd), $sampled(wr_data_even),
                                   exp_head.odd_word, exp_head.even_word));

   a_disabled_quiet: assert property (@(posedge nclk) disable iff (reset)
      dcache_disable |-> !wr_valid)
      else stop_on_error($sformatf("FAILED at %0t: write issued with the cache disabled",
                                   $time));

   a_stall_hold: assert property (@(posedge nclk) disable iff (reset)
      (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr_way) && $stable(wr_index) &&
                                   $stable(wr_byte_en) && $stable(wr_data_even) &&
                                   $stable(wr_data_odd)))
      else stop_on_error($sformatf("FAILED at %0t: write fields changed while stalled", $time));

   initial begin
      req_valid = 1'b0;
      req_addr = '0;
      req_op_size = OP_SIZE_1;
      req_le_mode = 1'b0;
      req_byte_en = '0;
      req_data = '0;
      req_par = '0;
      req_way_en = '0;
      dcache_disable = 1'b0;
      way_perr_inval = '0;
      wr_ready = 1'b1;
      repeat (3) @(posedge nclk);
      #1;
      reset = 1'b0;

      // Every size, offset and endian mode at full rate
      for (int sel = 0; sel < 5; sel++) begin
         for (int off = 0; off < QW_BYTES; off++) begin
            send_request(size_code_of(sel), 4'(off), 1'b0);
            send_request(size_code_of(sel), 4'(off), 1'b1);
         end
      end
      drain_pipeline();

      stall_mode = 1'b1;
      repeat (80) send_random();
      drain_pipeline();

      dcache_disable = 1'b1;
      stall_mode = 1'b1;
      repeat (20) send_random();
      drain_pipeline();
      dcache_disable = 1'b0;

      way_perr_inval = 8'b1010_0110;
      stall_mode = 1'b1;
      repeat (40) send_random();
      drain_pipeline();

      if (exp_q.size() != 0) begin
         stop_on_error($sformatf("%0d expected writes never reached the array",
                                 exp_q.size()));
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule
